// File: list.f
+incdir+logic
logic/conv_data_pkg.sv
logic/conv_ctrl_pkg.sv
logic/conv_control.sv
logic/patch_counter.sv
logic/window_buffer.sv
logic/row_mac.sv
logic/conv_engine.sv
tb/conv_engine_asserts.sv
tb/conv_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_engine_tb -Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vconv_engine_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/conv_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_engine_tb
    import conv_data_pkg::*;
();

    localparam int IMG_W          = `CONV_IMG_W;
    localparam int K              = `CONV_K;
    localparam int OUT_W          = `CONV_OUT_W;
    localparam int PATCHES        = `CONV_PATCHES;
    localparam int RUN_CYCLES     = PATCHES * 10 + 2;
    localparam int LOAD_CYCLES    = IMG_W * IMG_W + K * K + 1;
    localparam int TIMEOUT_CYCLES = 6 * RUN_CYCLES + 4 * LOAD_CYCLES;

    logic      clk;
    logic      rst_n;
    logic      start;
    logic      pix_we;
    pix_addr_t pix_addr;
    pixel_t    pix_data;
    logic      wgt_we;
    wgt_addr_t wgt_addr;
    weight_t   wgt_data;
    logic      busy;
    logic      done;
    logic      result_valid;
    conv_sum_t result_data;
    coord_t    result_row;
    coord_t    result_col;

    // mirror of what the engine has accepted
    int img_m [0:IMG_W*IMG_W-1];
    int wgt_m [0:K*K-1];
    int seed;
    int errors;
    int errors_before;
    int tests_run;
    int res_idx;
    int results_seen;
    int cycles;

    conv_engine u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .pix_we       (pix_we),
        .pix_addr     (pix_addr),
        .pix_data     (pix_data),
        .wgt_we       (wgt_we),
        .wgt_addr     (wgt_addr),
        .wgt_data     (wgt_data),
        .busy         (busy),
        .done         (done),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_row   (result_row),
        .result_col   (result_col)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // nine-product sum of the patch whose top-left pixel is (row, col)
    function automatic int expected_sum(input int row, input int col);
        int sum;
        sum = 0;
        for (int i = 0; i < K; i++)
        begin
            for (int j = 0; j < K; j++)
            begin
                sum += img_m[(row + i) * IMG_W + col + j] * wgt_m[i * K + j];
            end
        end
        return sum;
    endfunction

    // result index within the current run
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            res_idx <= 0;
        end
        else if (start && !busy)
        begin
            res_idx <= 0;
        end
        else if (result_valid)
        begin
            res_idx <= res_idx + 1;
        end
    end

    // total results over all runs
    always @(posedge clk)
    begin
        if (rst_n && result_valid)
        begin
            results_seen++;
        end
    end

    a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> int'(result_data) == expected_sum(result_row, result_col))
    else
    begin
        errors++;
        $display("Mismatch at %0t: patch (%0d,%0d) expected %0d, got %0d", $time,
            $sampled(result_row), $sampled(result_col),
            expected_sum($sampled(result_row), $sampled(result_col)),
            $sampled(result_data));
    end

    a_result_order: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result_row == res_idx / OUT_W) && (result_col == res_idx % OUT_W))
    else
    begin
        errors++;
        $display("Mismatch at %0t: result %0d came as (%0d,%0d), expected (%0d,%0d)", $time,
            $sampled(res_idx), $sampled(result_row), $sampled(result_col),
            $sampled(res_idx) / OUT_W, $sampled(res_idx) % OUT_W);
    end

    a_count_at_done: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> res_idx == PATCHES)
    else
    begin
        errors++;
        $display("Mismatch at %0t: %0d results before done, expected %0d", $time,
            $sampled(res_idx), PATCHES);
    end

    a_busy_falls_at_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> done)
    else
    begin
        errors++;
        $display("busy dropped at %0t without done being raised", $time);
    end

    // the sticky flag itself, the output is masked by busy
    a_start_clears_done: assert property (@(posedge clk) disable iff (!rst_n)
        start && !busy |=> !u_dut.run_done)
    else
    begin
        errors++;
        $display("done flag still set at %0t after a new start", $time);
    end

    a_reset_clears: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !busy && !done && !result_valid)
    else
    begin
        errors++;
        $display("busy, done or result_valid not cleared by reset at %0t", $time);
    end

    task automatic write_pixel(input int addr, input int value);
        @(negedge clk);
        wgt_we   = 1'b0;
        pix_we   = 1'b1;
        pix_addr = pix_addr_t'(addr);
        pix_data = pixel_t'(value);
        // writes only land while the engine is idle
        if (!busy)
        begin
            img_m[addr] = value & 255;
        end
    endtask

    task automatic write_weight(input int idx, input int value);
        @(negedge clk);
        pix_we   = 1'b0;
        wgt_we   = 1'b1;
        wgt_addr = wgt_addr_t'(idx);
        wgt_data = weight_t'(value);
        if (!busy)
        begin
            wgt_m[idx] = value;
        end
    endtask

    task automatic end_writes();
        @(negedge clk);
        pix_we = 1'b0;
        wgt_we = 1'b0;
    endtask

    task automatic write_random_data();
        for (int a = 0; a < IMG_W * IMG_W; a++)
        begin
            write_pixel(a, $random(seed) & 255);
        end
        for (int k = 0; k < K * K; k++)
        begin
            write_weight(k, ($random(seed) & 255) - 128);
        end
        end_writes();
    endtask

    task automatic start_run();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_run_done();
        while (!done)
        begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
            (errors == errors_before) ? "ok" : "FAILED");
        errors_before = errors;
    endtask

    // ends the run if the engine never finishes
    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        seed          = 42;
        errors        = 0;
        errors_before = 0;
        tests_run     = 0;
        results_seen  = 0;
        rst_n         = 1'b0;
        start         = 1'b0;
        pix_we        = 1'b0;
        pix_addr      = '0;
        pix_data      = '0;
        wgt_we        = 1'b0;
        wgt_addr      = '0;
        wgt_data      = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        write_random_data();
        start_run();
        wait_run_done();
        finish_test("random image and kernel");

        // image and kernel writes during the run must be dropped
        start_run();
        for (int n = 0; n < 10; n++)
        begin
            write_pixel($random(seed) & 63, $random(seed) & 255);
        end
        for (int k = 0; k < K * K; k++)
        begin
            write_weight(k, ($random(seed) & 255) - 128);
        end
        end_writes();
        wait_run_done();
        finish_test("writes while busy");

        // full-scale pixels, weights at both ends of the range
        for (int a = 0; a < IMG_W * IMG_W; a++)
        begin
            write_pixel(a, 255);
        end
        for (int k = 0; k < K * K; k++)
        begin
            write_weight(k, (k == 4) ? 127 : -128);
        end
        end_writes();
        start_run();
        wait_run_done();
        finish_test("extreme values");

        start_run();
        repeat (100) @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        start_run();
        wait_run_done();
        finish_test("reset during a run");

        repeat (4) @(negedge clk);
        $display("%0d tests, %0d results checked, %0d errors", tests_run, results_seen, errors);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/conv_engine_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module conv_engine_asserts
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input wire logic          clk,
    input wire logic          rst_n,
    input wire logic          start,
    input wire logic          busy,
    input wire logic          done,
    input wire logic          result_valid,
    input wire ctrl_strobes_t ctrl
);

    localparam logic [7:0] FIRST_RESULT_CYCLES = 8'd9;
    localparam logic [7:0] PATCH_CYCLES        = 8'd10;

    logic       run_start;
    logic [7:0] since_start;
    logic [7:0] since_result;
    logic       first_pending;
    logic       seen_result;

    assign run_start = start && !busy;

    // saturating cycle counts since start and since the last result
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            since_start   <= '0;
            since_result  <= '0;
            first_pending <= 1'b0;
            seen_result   <= 1'b0;
        end
        else
        begin
            if (run_start)
            begin
                since_start <= 8'd1;
            end
            else if (since_start != 8'hff)
            begin
                since_start <= since_start + 8'd1;
            end
            if (result_valid)
            begin
                since_result <= 8'd1;
            end
            else if (since_result != 8'hff)
            begin
                since_result <= since_result + 8'd1;
            end
            if (run_start)
            begin
                first_pending <= 1'b1;
                seen_result   <= 1'b0;
            end
            else if (result_valid)
            begin
                first_pending <= 1'b0;
                seen_result   <= 1'b1;
            end
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.addr, ctrl.load, ctrl.row_sel != 2'd0, ctrl.acc_enable,
                  ctrl.store, ctrl.counter_enable}))
        else $error("more than one sequencer strobe active at once");

    a_quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !result_valid)
        else $error("result seen while the engine is idle");

    a_first_latency: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && first_pending |-> since_start == FIRST_RESULT_CYCLES)
        else $error("first result not 9 cycles after start");

    a_result_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && seen_result |-> since_result == PATCH_CYCLES)
        else $error("results not 10 cycles apart");

    // done holds with the engine idle until the next start
    a_done_holds: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> done && !busy)
        else $error("done dropped or busy rose without a new start");

endmodule

bind conv_engine conv_engine_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .result_valid (result_valid),
    .ctrl         (ctrl)
);

`default_nettype wire

// File: logic/conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

module conv_engine
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      start,
    input  wire logic      pix_we,
    input  wire pix_addr_t pix_addr,
    input  wire pixel_t    pix_data,
    input  wire logic      wgt_we,
    input  wire wgt_addr_t wgt_addr,
    input  wire weight_t   wgt_data,
    output logic           busy,
    output logic           done,
    output logic           result_valid,
    output conv_sum_t      result_data,
    output coord_t         result_row,
    output coord_t         result_col
);

    ctrl_strobes_t ctrl;
    coord_t        out_row;
    coord_t        out_col;
    window_t       window;
    logic          run_done;

    // flag is already set in CHECK_DONE, show it once the engine is idle
    assign done = run_done & ~busy;

    conv_control u_control (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .done  (run_done),
        .ctrl  (ctrl),
        .busy  (busy)
    );

    patch_counter u_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .ctrl    (ctrl),
        .out_row (out_row),
        .out_col (out_col),
        .done    (run_done)
    );

    window_buffer u_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .busy     (busy),
        .pix_we   (pix_we),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .ctrl     (ctrl),
        .out_row  (out_row),
        .out_col  (out_col),
        .window   (window)
    );

    row_mac u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .busy         (busy),
        .wgt_we       (wgt_we),
        .wgt_addr     (wgt_addr),
        .wgt_data     (wgt_data),
        .ctrl         (ctrl),
        .window       (window),
        .out_row      (out_row),
        .out_col      (out_col),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_row   (result_row),
        .result_col   (result_col)
    );

endmodule

`default_nettype wire

// File: logic/row_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module row_mac
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          busy,
    input  wire logic          wgt_we,
    input  wire wgt_addr_t     wgt_addr,
    input  wire weight_t       wgt_data,
    input  wire ctrl_strobes_t ctrl,
    input  wire window_t       window,
    input  wire coord_t        out_row,
    input  wire coord_t        out_col,
    output logic               result_valid,
    output conv_sum_t          result_data,
    output coord_t             result_row,
    output coord_t             result_col
);

    localparam int NUM_WGT = `CONV_K * `CONV_K;

    weight_t              wgt [0:NUM_WGT-1];
    pixel_t [0:`CONV_K-1] sel_pix;
    wgt_addr_t            sel_base;
    product_t             prod [0:`CONV_K-1];
    row_sum_t             row_sum_next;
    row_sum_t             row_sum_q;
    logic                 row_valid_q;
    conv_sum_t            partial;
    conv_sum_t            acc;

    always_ff @(posedge clk)
    begin
        if (wgt_we && !busy && (wgt_addr < wgt_addr_t'(NUM_WGT)))
        begin
            wgt[wgt_addr] <= wgt_data;
        end
    end

    // pick pixel row and first weight index of that kernel row
    always_comb
    begin
        case (ctrl.row_sel)
            2'd2:
            begin
                sel_pix  = window.r1;
                sel_base = wgt_addr_t'(3);
            end
            2'd3:
            begin
                sel_pix  = window.r2;
                sel_base = wgt_addr_t'(6);
            end
            default:
            begin
                sel_pix  = window.r0;
                sel_base = wgt_addr_t'(0);
            end
        endcase
        for (int j = 0; j < `CONV_K; j++)
        begin
            // zero-extend the pixel so the multiply stays signed
            prod[j] = $signed({1'b0, sel_pix[j]}) * wgt[sel_base + wgt_addr_t'(j)];
        end
        row_sum_next = row_sum_t'(prod[0]) + row_sum_t'(prod[1]) + row_sum_t'(prod[2]);
    end

    always_ff @(posedge clk)
    begin
        row_sum_q <= row_sum_next;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row_valid_q  <= 1'b0;
            partial      <= '0;
            acc          <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            row_valid_q  <= (ctrl.row_sel != 2'd0);
            result_valid <= ctrl.store;
            // registered row sum lands one cycle after its MAC step
            if (ctrl.flush_acc)
            begin
                partial <= '0;
            end
            else if (row_valid_q)
            begin
                partial <= partial + conv_sum_t'(row_sum_q);
            end
            if (ctrl.acc_enable)
            begin
                acc <= partial;
            end
        end
    end

    // counters still hold this patch during STORE
    always_ff @(posedge clk)
    begin
        if (ctrl.store)
        begin
            result_data <= acc;
            result_row  <= out_row;
            result_col  <= out_col;
        end
    end

endmodule

`default_nettype wire

// File: logic/window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module window_buffer
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          busy,
    input  wire logic          pix_we,
    input  wire pix_addr_t     pix_addr,
    input  wire pixel_t        pix_data,
    input  wire ctrl_strobes_t ctrl,
    input  wire coord_t        out_row,
    input  wire coord_t        out_col,
    output window_t            window
);

    localparam int NUM_PIX = `CONV_IMG_W * `CONV_IMG_W;

    pixel_t  img [0:NUM_PIX-1];
    coord_t  base_row;
    coord_t  base_col;
    window_t win_next;

    // image is 8 wide, so the address is just {row, col}
    function automatic pix_addr_t pix_index(input coord_t row, input coord_t col);
        return {row, col};
    endfunction

    // image store, frozen during a run
    always_ff @(posedge clk)
    begin
        if (pix_we && !busy)
        begin
            img[pix_addr] <= pix_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            base_row <= '0;
            base_col <= '0;
        end
        else if (ctrl.addr)
        begin
            base_row <= out_row;
            base_col <= out_col;
        end
    end

    // 3x3 neighbourhood at the latched base
    always_comb
    begin
        for (int j = 0; j < `CONV_K; j++)
        begin
            win_next.r0[j] = img[pix_index(base_row, base_col + coord_t'(j))];
            win_next.r1[j] = img[pix_index(base_row + coord_t'(1), base_col + coord_t'(j))];
            win_next.r2[j] = img[pix_index(base_row + coord_t'(2), base_col + coord_t'(j))];
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load)
        begin
            window <= win_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/patch_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module patch_counter
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          start,
    input  wire ctrl_strobes_t ctrl,
    output coord_t             out_row,
    output coord_t             out_col,
    output logic               done
);

    localparam coord_t LAST = coord_t'(`CONV_OUT_W - 1);

    logic last_col;
    logic last_patch;

    assign last_col   = (out_col == LAST);
    assign last_patch = last_col && (out_row == LAST);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_row <= '0;
            out_col <= '0;
            done    <= 1'b0;
        end
        else if (start)
        begin
            out_row <= '0;
            out_col <= '0;
            done    <= 1'b0;
        end
        else if (ctrl.counter_enable)
        begin
            if (last_patch)
            begin
                // wrap to the origin, done stays set until next start
                out_row <= '0;
                out_col <= '0;
                done    <= 1'b1;
            end
            else if (last_col)
            begin
                out_col <= '0;
                out_row <= out_row + coord_t'(1);
            end
            else
            begin
                out_col <= out_col + coord_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_control.sv
`timescale 1ns/1ps
`default_nettype none

module conv_control
    import conv_ctrl_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    start,
    input  wire logic    done,
    output ctrl_strobes_t ctrl,
    output logic          busy
);

    seq_state_t state;
    seq_state_t next_state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // next state and strobe decode
    always_comb
    begin
        ctrl       = '0;
        next_state = state;

        case (state)
            IDLE:
            begin
                if (start)
                begin
                    next_state = ADDR;
                end
            end
            ADDR:
            begin
                // latch patch base, start a fresh partial sum
                ctrl.addr      = 1'b1;
                ctrl.flush_acc = 1'b1;
                next_state     = LOAD;
            end
            LOAD:
            begin
                ctrl.load  = 1'b1;
                next_state = MAC0;
            end
            MAC0:
            begin
                ctrl.row_sel = row_sel_t'(2'd1);
                next_state   = MAC1;
            end
            MAC1:
            begin
                ctrl.row_sel = row_sel_t'(2'd2);
                next_state   = MAC2;
            end
            MAC2:
            begin
                ctrl.row_sel = row_sel_t'(2'd3);
                next_state   = SUM;
            end
            SUM:
            begin
                // last row sum drains into the partial sum here
                next_state = ACC;
            end
            ACC:
            begin
                ctrl.acc_enable = 1'b1;
                next_state      = STORE;
            end
            STORE:
            begin
                ctrl.store = 1'b1;
                next_state = UPDATE_COUNTERS;
            end
            UPDATE_COUNTERS:
            begin
                ctrl.counter_enable = 1'b1;
                next_state          = CHECK_DONE;
            end
            CHECK_DONE:
            begin
                if (done)
                begin
                    next_state = IDLE;
                end
                else
                begin
                    next_state = ADDR;
                end
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

// File: logic/conv_ctrl_pkg.sv
`default_nettype none

package conv_ctrl_pkg;

    typedef enum logic [3:0] {
        IDLE,
        ADDR,
        LOAD,
        MAC0,
        MAC1,
        MAC2,
        SUM,
        ACC,
        STORE,
        UPDATE_COUNTERS,
        CHECK_DONE
    } seq_state_t;

    // 0 selects no row, 1..3 select kernel rows 0..2
    typedef logic [1:0] row_sel_t;

    typedef struct packed {
        logic     addr;
        logic     load;
        row_sel_t row_sel;
        logic     flush_acc;
        logic     acc_enable;
        logic     store;
        logic     counter_enable;
    } ctrl_strobes_t;

endpackage

`default_nettype wire

// File: logic/conv_data_pkg.sv
`default_nettype none

`include "conv_consts.svh"

package conv_data_pkg;

    typedef logic        [`CONV_PIX_BITS-1:0] pixel_t;
    typedef logic signed [`CONV_WGT_BITS-1:0] weight_t;
    typedef logic        [5:0]                pix_addr_t;
    // kernel index 0 to 8
    typedef logic        [3:0]                wgt_addr_t;
    typedef logic        [2:0]                coord_t;

    // unsigned pixel times signed weight
    typedef logic signed [`CONV_PIX_BITS+`CONV_WGT_BITS:0] product_t;
    typedef logic signed [`CONV_SUM_BITS-2:0]              row_sum_t;
    typedef logic signed [`CONV_SUM_BITS-1:0]              conv_sum_t;

    // row r0 is the top row of the patch
    typedef struct packed {
        pixel_t [0:`CONV_K-1] r0;
        pixel_t [0:`CONV_K-1] r1;
        pixel_t [0:`CONV_K-1] r2;
    } window_t;

endpackage

`default_nettype wire

// File: logic/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// image is square, CONV_IMG_W pixels on each side
`define CONV_IMG_W    8
`define CONV_K        3
// valid patches per row and per column
`define CONV_OUT_W    6
`define CONV_PATCHES  36

`define CONV_PIX_BITS 8
`define CONV_WGT_BITS 8
// nine full-range products need 20 bits
`define CONV_SUM_BITS 20

`endif
